//--- hdl/robotSenseSettings.svh
`ifndef ROBOT_SENSE_SETTINGS_SVH
`define ROBOT_SENSE_SETTINGS_SVH

// ====================
// sizes
// ====================
`define NUM_ENC 7 // encoder channels
`define NUM_SWITCH 5
`define SPEED_W 16 // counts, speeds and tower angles

// ====================
// APB
// ====================
`define APB_AW 8
`define APB_DW 32

// ====================
// timing and polarity
// ====================
// channel order: prop L, prop R, rake L, rake R, gripper, odo L, odo R
// prop R and odo L are mounted mirrored
`define DIR_INVERT_MASK 7'b0100010
`define GLITCH_TICKS 20 // tower edges without laser before the beacon closes
`define DEFAULT_WINDOW 500000 // 10 ms at 50 MHz

`endif

//--- hdl/robotSensePkg.sv
`include "robotSenseSettings.svh"

package robotSensePkg;

	typedef logic [`SPEED_W-1:0] speedT; // count, speed or angle
	typedef logic [`NUM_ENC-1:0] encVecT; // one bit per channel

	// byte addresses of the 32-bit registers
	typedef enum logic [`APB_AW-1:0] {
		ADDR_STATUS       = 8'h00,
		ADDR_SPEED0       = 8'h04,
		ADDR_SPEED1       = 8'h08,
		ADDR_SPEED2       = 8'h0C,
		ADDR_SPEED3       = 8'h10,
		ADDR_SPEED4       = 8'h14,
		ADDR_SPEED5       = 8'h18,
		ADDR_SPEED6       = 8'h1C,
		ADDR_BEACON_START = 8'h20,
		ADDR_BEACON_END   = 8'h24,
		ADDR_EPOCH        = 8'h28
	} regAddrT;

	typedef enum logic [1:0] {
		BEACON_IDLE      = 2'd0,
		BEACON_RECEIVING = 2'd1,
		BEACON_GAP       = 2'd2 // laser lost, maybe only a glitch
	} beaconStateT;

endpackage

//--- hdl/lineSync.sv
module lineSync #(
	parameter int width = 1
) (
	input  logic             CLOCK_50,
	input  logic             reset,
	input  logic [width-1:0] lineIn,
	output logic [width-1:0] lineLevel,
	output logic [width-1:0] lineRise
);

	logic [width-1:0] metaStage; // first flop, may go metastable
	logic [width-1:0] syncStage;
	logic [width-1:0] history; // level one cycle back

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			metaStage <= '0;
			syncStage <= '0;
			history   <= '0;
		end else begin
			metaStage <= lineIn;
			syncStage <= metaStage;
			history   <= syncStage;
		end
	end

	assign lineLevel = syncStage;
	assign lineRise  = syncStage & ~history; // single-cycle pulse per rising edge

	// a rise pulse never lasts longer than one cycle
	risePulseSingle: assert property (@(posedge CLOCK_50) disable iff (reset)
		!(|(lineRise & $past(lineRise))));

endmodule

//--- hdl/quadChannel.sv
`include "robotSenseSettings.svh"

module quadChannel
	import robotSensePkg::*;
#(
	parameter bit invertDir = 1'b0
) (
	input  logic  CLOCK_50,
	input  logic  reset,
	input  logic  riseA,
	input  logic  riseB,
	input  logic  levelB,
	input  logic  windowEnd,
	output speedT speed,
	output logic  dir
);

	speedT countA;
	speedT countB;
	logic [`SPEED_W:0] countSum; // one bit wider so the carry survives

	assign countSum = {1'b0, countA} + {1'b0, countB};

	// ====================
	// edge counters
	// ====================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			countA <= '0;
			countB <= '0;
		end else if (windowEnd) begin
			// restart, an edge right now belongs to the new window
			countA <= speedT'(riseA);
			countB <= speedT'(riseB);
		end else begin
			if (riseA && (countA != '1)) begin
				countA <= countA + 1'b1; // stops at all ones
			end
			if (riseB && (countB != '1)) begin
				countB <= countB + 1'b1;
			end
		end
	end

	// ====================
	// speed and direction
	// ====================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			speed <= '0;
		end else if (windowEnd) begin
			speed <= countSum[`SPEED_W:1]; // average of A and B, rounded down
		end
	end

	// B level seen at the A rise gives the turning sense
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			dir <= 1'b0;
		end else if (riseA) begin
			dir <= levelB ^ invertDir;
		end
	end

	// speed moves only right after the window closes
	speedAtWindowEnd: assert property (@(posedge CLOCK_50) disable iff (reset)
		$changed(speed) |-> $past(windowEnd));

endmodule

//--- hdl/encoderBank.sv
`include "robotSenseSettings.svh"

module encoderBank
	import robotSensePkg::*;
#(
	parameter int windowCycles = `DEFAULT_WINDOW
) (
	input  logic   CLOCK_50,
	input  logic   reset,
	input  encVecT riseA,
	input  encVecT riseB,
	input  encVecT levelB,
	output speedT  speeds [0:`NUM_ENC-1],
	output encVecT dirs,
	output speedT  epoch
);

	localparam int TIMER_W = $clog2(windowCycles);
	localparam encVecT DIR_MASK = `DIR_INVERT_MASK;

	logic [TIMER_W-1:0] windowTimer;
	logic               windowEnd;

	assign windowEnd = (windowTimer == TIMER_W'(windowCycles - 1)); // last clock of the window

	// ====================
	// window timer, epoch
	// ====================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			windowTimer <= '0;
			epoch       <= '0;
		end else if (windowEnd) begin
			windowTimer <= '0;
			epoch       <= epoch + 1'b1; // lets software spot a fresh set of speeds
		end else begin
			windowTimer <= windowTimer + 1'b1;
		end
	end

	// one counter pair per encoder, all sharing the same window
	for (genvar ch = 0; ch < `NUM_ENC; ch++) begin : gChannel
		quadChannel #(
			.invertDir(DIR_MASK[ch])
		) channel (
			.CLOCK_50 (CLOCK_50),
			.reset    (reset),
			.riseA    (riseA[ch]),
			.riseB    (riseB[ch]),
			.levelB   (levelB[ch]),
			.windowEnd(windowEnd),
			.speed    (speeds[ch]),
			.dir      (dirs[ch])
		);
	end

endmodule

//--- hdl/beaconCapture.sv
`include "robotSenseSettings.svh"

module beaconCapture
	import robotSensePkg::*;
(
	input  logic  CLOCK_50,
	input  logic  reset,
	input  logic  towerRise, // tower encoder A edge
	input  logic  syncRise, // once per revolution
	input  logic  sign, // laser seen
	output speedT beaconStart,
	output speedT beaconEnd,
	output logic  beaconValid,
	output logic  turn
);

	localparam int GAP_W = $clog2(`GLITCH_TICKS + 1);

	beaconStateT        state;
	speedT              angle;
	speedT              pendingStart;
	speedT              pendingEnd;
	logic [GAP_W-1:0]   gapCount;

	// ====================
	// tower angle, turn
	// ====================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			angle <= '0;
			turn  <= 1'b0;
		end else begin
			if (syncRise) begin
				angle <= '0; // sync wins over a coincident tower edge
				turn  <= ~turn;
			end else if (towerRise) begin
				angle <= angle + 1'b1;
			end
		end
	end

	// ====================
	// beacon FSM
	// ====================
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			state       <= BEACON_IDLE;
			gapCount    <= '0;
			beaconStart <= '0;
			beaconEnd   <= '0;
			beaconValid <= 1'b0;
		end else begin
			beaconValid <= 1'b0;
			case (state)
				BEACON_IDLE: begin
					if (sign) begin
						state <= BEACON_RECEIVING;
					end
				end
				BEACON_RECEIVING: begin
					if (!sign) begin
						gapCount <= '0;
						state    <= BEACON_GAP;
					end
				end
				BEACON_GAP: begin
					if (sign) begin
						state <= BEACON_RECEIVING; // just a glitch, start is kept
					end else if (gapCount == GAP_W'(`GLITCH_TICKS)) begin
						beaconStart <= pendingStart;
						beaconEnd   <= pendingEnd;
						beaconValid <= 1'b1;
						state       <= BEACON_IDLE;
					end else if (towerRise) begin
						gapCount <= gapCount + 1'b1;
					end
				end
				default: begin
					state <= BEACON_IDLE;
				end
			endcase
		end
	end

	// angles of the beacon under reception
	always_ff @(posedge CLOCK_50) begin
		if ((state == BEACON_IDLE) && sign) begin
			pendingStart <= angle;
		end
		if ((state == BEACON_RECEIVING) && !sign) begin
			pendingEnd <= angle; // overwritten if the gap turns out to be a glitch
		end
	end

	// a result is only published when a gap runs out
	validFromGap: assert property (@(posedge CLOCK_50) disable iff (reset)
		beaconValid |-> (state == BEACON_IDLE) && ($past(state) == BEACON_GAP));

endmodule

//--- hdl/sensorRegs.sv
`include "robotSenseSettings.svh"

module sensorRegs
	import robotSensePkg::*;
(
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  logic [`APB_AW-1:0]     paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_DW-1:0]     pwdata,
	output logic [`APB_DW-1:0]     prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  speedT                  speeds [0:`NUM_ENC-1],
	input  encVecT                 dirs,
	input  speedT                  epoch,
	input  speedT                  beaconStart,
	input  speedT                  beaconEnd,
	input  logic                   beaconValid,
	input  logic                   turn,
	input  logic [`NUM_SWITCH-1:0] switches,
	input  logic                   startLevel,
	input  logic                   idLevel
);

	logic                beaconNew; // sticky until the end angle is read
	logic [`APB_DW-1:0]  statusWord;
	logic [`APB_DW-1:0]  readData;
	logic                addrHit;
	logic [2:0]          speedIdx;
	logic                setupPhase;

	assign setupPhase = psel && !penable;
	assign speedIdx   = paddr[4:2] - 3'd1; // 0x04 maps to channel 0
	assign statusWord = {{(`APB_DW - 16){1'b0}}, beaconNew, turn, startLevel, switches,
		dirs, idLevel};

	// ====================
	// address decode
	// ====================
	always_comb begin
		readData = '0;
		addrHit  = 1'b1;
		if (paddr[1:0] != 2'b00) begin
			addrHit = 1'b0; // unaligned
		end else begin
			case (regAddrT'(paddr))
				ADDR_STATUS: readData = statusWord;
				ADDR_SPEED0, ADDR_SPEED1, ADDR_SPEED2, ADDR_SPEED3,
				ADDR_SPEED4, ADDR_SPEED5, ADDR_SPEED6: readData = `APB_DW'(speeds[speedIdx]);
				ADDR_BEACON_START: readData = `APB_DW'(beaconStart);
				ADDR_BEACON_END: readData = `APB_DW'(beaconEnd);
				ADDR_EPOCH: readData = `APB_DW'(epoch);
				default: addrHit = 1'b0;
			endcase
		end
	end

	// response is prepared in setup so it is stable through the access cycle
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			pready    <= 1'b0;
			pslverr   <= 1'b0;
			prdata    <= '0;
			beaconNew <= 1'b0;
		end else begin
			pready <= setupPhase;
			if (setupPhase) begin
				if (pwrite || !addrHit) begin
					prdata  <= '0; // read-only map
					pslverr <= 1'b1;
				end else begin
					prdata  <= readData;
					pslverr <= 1'b0;
				end
			end
			if (beaconValid) begin
				beaconNew <= 1'b1; // a fresh beacon beats a clearing read
			end else if (psel && penable && !pwrite && (paddr == ADDR_BEACON_END)) begin
				beaconNew <= 1'b0;
			end
		end
	end

	// master must keep psel up through the access cycle
	readyInTransfer: assert property (@(posedge CLOCK_50) disable iff (reset)
		pready |-> psel);

	// write data is ignored, but the master still has to drive it
	writeDataKnown: assert property (@(posedge CLOCK_50) disable iff (reset)
		(psel && penable && pwrite) |-> !$isunknown(pwdata));

endmodule

//--- hdl/robotSense.sv
`include "robotSenseSettings.svh"

module robotSense
	import robotSensePkg::*;
#(
	parameter int windowCycles = `DEFAULT_WINDOW
) (
	input  logic                   CLOCK_50,
	input  logic                   reset,
	input  encVecT                 encA,
	input  encVecT                 encB,
	input  logic                   towerA,
	input  logic                   laserSync,
	input  logic                   laserSign,
	input  logic [`NUM_SWITCH-1:0] microSwitch,
	input  logic                   startPin,
	input  logic                   robotId,
	input  logic [`APB_AW-1:0]     paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_DW-1:0]     pwdata,
	output logic [`APB_DW-1:0]     prdata,
	output logic                   pready,
	output logic                   pslverr
);

	// ====================
	// positions in the synchronized bus
	// ====================
	localparam int B_LSB     = `NUM_ENC;
	localparam int TOWER_BIT = 2 * `NUM_ENC;
	localparam int SYNC_BIT  = TOWER_BIT + 1;
	localparam int SIGN_BIT  = TOWER_BIT + 2;
	localparam int SW_LSB    = TOWER_BIT + 3;
	localparam int START_BIT = SW_LSB + `NUM_SWITCH;
	localparam int ID_BIT    = START_BIT + 1;
	localparam int LINES     = ID_BIT + 1;

	logic [LINES-1:0] syncLevel;
	logic [LINES-1:0] syncRise;

	speedT  speeds [0:`NUM_ENC-1];
	encVecT dirs;
	speedT  epoch;
	speedT  beaconStart;
	speedT  beaconEnd;
	logic   beaconValid;
	logic   turn;

	lineSync #(.width(LINES)) lines (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.lineIn   ({robotId, startPin, microSwitch, laserSign, laserSync, towerA, encB, encA}),
		.lineLevel(syncLevel),
		.lineRise (syncRise)
	);

	encoderBank #(.windowCycles(windowCycles)) encoders (
		.CLOCK_50(CLOCK_50),
		.reset   (reset),
		.riseA   (syncRise[B_LSB-1:0]),
		.riseB   (syncRise[TOWER_BIT-1:B_LSB]),
		.levelB  (syncLevel[TOWER_BIT-1:B_LSB]),
		.speeds  (speeds),
		.dirs    (dirs),
		.epoch   (epoch)
	);

	beaconCapture beacon (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.towerRise  (syncRise[TOWER_BIT]),
		.syncRise   (syncRise[SYNC_BIT]),
		.sign       (syncLevel[SIGN_BIT]),
		.beaconStart(beaconStart),
		.beaconEnd  (beaconEnd),
		.beaconValid(beaconValid),
		.turn       (turn)
	);

	sensorRegs regs (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.speeds     (speeds),
		.dirs       (dirs),
		.epoch      (epoch),
		.beaconStart(beaconStart),
		.beaconEnd  (beaconEnd),
		.beaconValid(beaconValid),
		.turn       (turn),
		.switches   (syncLevel[START_BIT-1:SW_LSB]),
		.startLevel (syncLevel[START_BIT]),
		.idLevel    (syncLevel[ID_BIT])
	);

endmodule

//--- testbench/clockGen.sv
module clockGen (
	output logic CLOCK_50,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge CLOCK_50); // held for two rising edges
		reset <= 1'b0;
	end

endmodule

//--- testbench/robotSenseTb.sv
`include "robotSenseSettings.svh"

module robotSenseTb
	import robotSensePkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WINDOW = 400;
	localparam int NUM_ROWS = 8;
	localparam int MAX_PULSES = 30; // 10 cycles per pulse slot within 300 cycles
	localparam int MAX_TICKS = 65;
	localparam int WATCHDOG_NS = NUM_ROWS * (3 * WINDOW + MAX_TICKS * 20) * 10 * 2;
	localparam encVecT DIR_MASK = `DIR_INVERT_MASK;

	logic                   CLOCK_50;
	logic                   reset;
	encVecT                 encA;
	encVecT                 encB;
	logic                   towerA;
	logic                   laserSync;
	logic                   laserSign;
	logic [`NUM_SWITCH-1:0] microSwitch;
	logic                   startPin;
	logic                   robotId;
	logic [`APB_AW-1:0]     paddr;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`APB_DW-1:0]     pwdata;
	logic [`APB_DW-1:0]     prdata;
	logic                   pready;
	logic                   pslverr;

	int errorCount = 0;

	// ====================
	// stimulus and expected values
	// ====================
	int                     cntA [NUM_ROWS][`NUM_ENC];
	int                     cntB [NUM_ROWS][`NUM_ENC];
	encVecT                 phaseTab [NUM_ROWS]; // set where B leads A
	logic [`NUM_SWITCH-1:0] switchTab [NUM_ROWS];
	logic                   startTab [NUM_ROWS];
	logic                   idTab [NUM_ROWS];
	// per beacon the first lit tick, length, glitch gap (0 for none), second length and ticks
	int bcnFirst [NUM_ROWS] = '{3, 10, 2, 15, 5, 1, 4, 8};
	int bcnLen   [NUM_ROWS] = '{6, 4, 5, 8, 3, 10, 2, 12};
	int bcnGap   [NUM_ROWS] = '{0, 5, 25, 0, 19, 0, 20, 3};
	int bcnLen2  [NUM_ROWS] = '{0, 3, 4, 0, 2, 0, 6, 1};
	int bcnTicks [NUM_ROWS] = '{35, 50, 65, 50, 55, 40, 60, 50};
	int                     expSpeed [NUM_ROWS][`NUM_ENC];
	encVecT                 expDirs [NUM_ROWS];
	int                     expStart [NUM_ROWS];
	int                     expEnd [NUM_ROWS];

	clockGen clocks (
		.CLOCK_50(CLOCK_50),
		.reset   (reset)
	);

	robotSense #(.windowCycles(WINDOW)) dut0 (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.encA       (encA),
		.encB       (encB),
		.towerA     (towerA),
		.laserSync  (laserSync),
		.laserSign  (laserSign),
		.microSwitch(microSwitch),
		.startPin   (startPin),
		.robotId    (robotId),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	function automatic void buildTable();
		encVecT dirNow;
		int     gapEnd;
		dirNow = '0; // direction flops come out of reset low
		for (int r = 0; r < NUM_ROWS; r++) begin
			phaseTab[r] = encVecT'($urandom);
			switchTab[r] = `NUM_SWITCH'($urandom);
			startTab[r] = 1'($urandom);
			idTab[r] = 1'($urandom);
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				cntA[r][ch] = (r == NUM_ROWS - 1) ? MAX_PULSES : int'($urandom % 31);
				cntB[r][ch] = (r == NUM_ROWS - 1) ? MAX_PULSES : int'($urandom % 31);
				expSpeed[r][ch] = (cntA[r][ch] + cntB[r][ch]) / 2;
				// B is high at the last A rise only if that slot carries a B pulse
				if (cntA[r][ch] > 0) begin
					dirNow[ch] = (phaseTab[r][ch] && (cntA[r][ch] <= cntB[r][ch])) ^ DIR_MASK[ch];
				end
			end
			expDirs[r] = dirNow;
			gapEnd = bcnFirst[r] + bcnLen[r] + bcnGap[r];
			if (bcnGap[r] >= `GLITCH_TICKS) begin
				expStart[r] = gapEnd; // the second beacon replaces the first
				expEnd[r] = gapEnd + bcnLen2[r];
			end else begin
				expStart[r] = bcnFirst[r];
				expEnd[r] = (bcnGap[r] > 0) ? gapEnd + bcnLen2[r] : bcnFirst[r] + bcnLen[r];
			end
		end
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
			errorCount++;
		end
	endtask

	// ====================
	// APB master
	// ====================
	task automatic apbTransfer(input logic [7:0] addr, input logic write,
		output logic [31:0] data, output logic err);
		@(posedge CLOCK_50);
		paddr   <= addr;
		pwrite  <= write;
		pwdata  <= $urandom;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(negedge CLOCK_50);
		check("pready in setup", 32'(pready), 32'd0);
		@(posedge CLOCK_50);
		penable <= 1'b1;
		@(negedge CLOCK_50);
		check("pready in access", 32'(pready), 32'd1); // no wait states
		data = prdata;
		err  = pslverr;
		@(posedge CLOCK_50);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apbTransfer(addr, 1'b0, data, err);
	endtask

	task automatic expectRead(input logic [7:0] addr, input string name,
		input logic [31:0] expected);
		logic [31:0] data;
		logic        err;
		apbRead(addr, data, err);
		check(name, data, expected);
		check({name, " pslverr"}, 32'(err), 32'd0);
	endtask

	task automatic expectError(input logic [7:0] addr, input logic write, input string name);
		logic [31:0] data;
		logic        err;
		apbTransfer(addr, write, data, err);
		check({name, " pslverr"}, 32'(err), 32'd1);
		check({name, " prdata"}, data, 32'd0);
	endtask

	// polls the epoch until the window timer wraps
	task automatic waitNewWindow(output logic [31:0] newEpoch);
		logic [31:0] oldEpoch;
		logic        err;
		int          polls;
		apbRead(ADDR_EPOCH, oldEpoch, err);
		newEpoch = oldEpoch;
		polls = 0;
		while ((newEpoch == oldEpoch) && (polls < 2 * WINDOW)) begin
			apbRead(ADDR_EPOCH, newEpoch, err);
			polls++;
		end
		if (newEpoch == oldEpoch) begin
			$display("Epoch register stuck at %0d, the window timer never wrapped", oldEpoch);
			errorCount++;
		end
	endtask

	// ====================
	// line drivers
	// ====================
	task automatic driveEncoders(input int row);
		encVecT aVec;
		encVecT bVec;
		for (int k = 0; k < MAX_PULSES; k++) begin
			for (int off = 0; off < 10; off++) begin
				for (int ch = 0; ch < `NUM_ENC; ch++) begin
					if (phaseTab[row][ch]) begin
						bVec[ch] = (k < cntB[row][ch]) && (off < 5);
						aVec[ch] = (k < cntA[row][ch]) && (off >= 2) && (off < 7);
					end else begin
						aVec[ch] = (k < cntA[row][ch]) && (off < 5);
						bVec[ch] = (k < cntB[row][ch]) && (off >= 2) && (off < 7);
					end
				end
				@(posedge CLOCK_50);
				encA <= aVec;
				encB <= bVec;
			end
		end
	endtask

	task automatic driveBeacon(input int row);
		logic laser;
		int   gapEnd;
		gapEnd = bcnFirst[row] + bcnLen[row] + bcnGap[row];
		@(posedge CLOCK_50);
		laserSync <= 1'b1; // start of a tower revolution
		repeat (5) @(posedge CLOCK_50);
		laserSync <= 1'b0;
		repeat (5) @(posedge CLOCK_50);
		for (int t = 0; t < bcnTicks[row]; t++) begin
			laser = ((t >= bcnFirst[row]) && (t < bcnFirst[row] + bcnLen[row]))
				|| ((bcnGap[row] > 0) && (t >= gapEnd) && (t < gapEnd + bcnLen2[row]));
			laserSign <= laser; // laser changes between tower edges
			repeat (5) @(posedge CLOCK_50);
			towerA <= 1'b1;
			repeat (10) @(posedge CLOCK_50);
			towerA <= 1'b0;
			repeat (5) @(posedge CLOCK_50);
		end
		laserSign <= 1'b0;
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		logic [31:0] epochBefore;
		logic [31:0] epochAfter;
		logic [31:0] data;
		logic        err;
		logic        turnNow;
		int          polls;
		encA <= '0;
		encB <= '0;
		towerA <= 1'b0;
		laserSync <= 1'b0;
		laserSign <= 1'b0;
		microSwitch <= '0;
		startPin <= 1'b0;
		robotId <= 1'b0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		void'($urandom(32'hce7f));
		buildTable();
		turnNow = 1'b0;
		@(negedge reset);
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge CLOCK_50);
			microSwitch <= switchTab[r];
			startPin <= startTab[r];
			robotId <= idTab[r];
			waitNewWindow(epochBefore);
			driveEncoders(r);
			waitNewWindow(epochAfter); // speeds of this window are now published
			check("epoch", epochAfter, epochBefore + 32'd1);
			for (int ch = 0; ch < `NUM_ENC; ch++) begin
				expectRead(8'(ADDR_SPEED0) + 8'(4 * ch), $sformatf("speed%0d", ch),
					expSpeed[r][ch]);
			end
			expectRead(ADDR_STATUS, "status", {16'h0, 1'b0, turnNow, startTab[r],
				switchTab[r], expDirs[r], idTab[r]});

			driveBeacon(r);
			turnNow = ~turnNow;
			polls = 0;
			data = '0;
			while (!data[15] && (polls < 50)) begin
				apbRead(ADDR_STATUS, data, err);
				polls++;
			end
			if (!data[15]) begin
				$display("Row %0d: status word never flagged a new beacon", r);
				errorCount++;
			end
			check("status turn", 32'(data[14]), 32'(turnNow));
			expectRead(ADDR_BEACON_START, "beaconStart", expStart[r]);
			expectRead(ADDR_BEACON_END, "beaconEnd", expEnd[r]);
			apbRead(ADDR_STATUS, data, err);
			check("status beacon flag", 32'(data[15]), 32'd0); // cleared by the end read
		end

		expectError(ADDR_STATUS, 1'b1, "write");
		expectError(8'h2C, 1'b0, "unmapped");
		expectError(8'h05, 1'b0, "unaligned");
		expectError(8'hFC, 1'b0, "top address");

		$display("Checks done with %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#WATCHDOG_NS;
		$display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

//--- src.f
+incdir+hdl
hdl/robotSensePkg.sv
hdl/lineSync.sv
hdl/quadChannel.sv
hdl/encoderBank.sv
hdl/beaconCapture.sv
hdl/sensorRegs.sv
hdl/robotSense.sv
testbench/clockGen.sv
testbench/robotSenseTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
	--top-module robotSenseTb -Mdir obj_dir -o robotSenseSim

./obj_dir/robotSenseSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
exit 1
